/* huff_pkg.sv */
/*
 * shared sizes and types for the huffman table builder
 * size defaults, index widths, packed length-write struct
 */
package huff_pkg;

   localparam int max_syms       = 16;
   localparam int max_len        = 8;
   localparam int syms_per_cycle = 2;

   // 0..max_len
   typedef logic [$clog2(max_len+1)-1:0]  len_t;
   // 0..max_syms-1
   typedef logic [$clog2(max_syms)-1:0]   sym_t;
   // 0..max_syms
   typedef logic [$clog2(max_syms+1)-1:0] depth_t;
   typedef logic [max_len-1:0]            code_t;

   // host length write
   typedef struct packed {
      logic valid;
      sym_t sym;
      len_t len;
   } len_wr_t;

endpackage

/* huff_len_regs.sv */
/*
 * host register block: per-symbol code lengths, latched depth,
 * start qualification and busy/done status
 */
`timescale 1ns/10ps

module huff_len_regs import huff_pkg::*; #(
   parameter int MAX_SYMS = max_syms
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  len_wr_t               len_wr,
   input  depth_t                depth,
   input  logic                  start,
   input  logic                  abort,
   input  logic                  code_last,
   output len_t [MAX_SYMS-1:0]   lens,
   output depth_t                active_depth,
   output logic                  start_build,
   output logic                  busy,
   output logic                  done
);

   assign start_build = start & ~busy; // only place start meets busy

   // length table, host writes locked out during a build
   always_ff @(posedge clk) begin
      if (len_wr.valid && !busy && (int'(len_wr.sym) < MAX_SYMS))
         lens[len_wr.sym] <= len_wr.len;
   end

   always_ff @(posedge clk) begin
      if (start_build)
         active_depth <= depth;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
         done <= 1'b0;
      end else begin
         done <= code_last & busy & ~abort;
         if (abort)
            busy <= 1'b0;
         else if (start_build)
            busy <= 1'b1;
         else if (code_last)
            busy <= 1'b0; // falls with done
      end
   end

endmodule

/* huff_first_code.sv */
/*
 * length histogram scan, one symbol per cycle, followed by the
 * canonical first-code walk that preloads the code counters
 */
`timescale 1ns/10ps

module huff_first_code import huff_pkg::*; #(
   parameter int MAX_SYMS = max_syms,
   parameter int MAX_LEN  = max_len
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start_build,
   input  logic                  abort,
   input  len_t [MAX_SYMS-1:0]   lens,
   input  depth_t                active_depth,
   output logic                  pre_wen,
   output len_t                  pre_len,
   output code_t                 pre_code,
   output logic                  table_ready
);

   typedef enum logic [1:0] {
      FC_IDLE,
      FC_SCAN,
      FC_PRELOAD,
      FC_READY
   } fc_state_t;

   fc_state_t             state;
   sym_t                  scan_idx;
   len_t                  len_idx;
   code_t                 run_code;
   depth_t [MAX_LEN:0]    hist;    // entry 0 stays zero
   len_t                  scan_len;
   code_t                 next_code;

   assign scan_len  = lens[scan_idx];
   assign next_code = code_t'((run_code + code_t'(hist[len_idx - 1'b1])) << 1);

   assign pre_wen     = (state == FC_PRELOAD);
   assign pre_len     = len_idx;
   assign pre_code    = next_code;
   assign table_ready = (state == FC_READY);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= FC_IDLE;
         scan_idx <= '0;
         len_idx  <= '0;
         run_code <= '0;
         hist     <= '0;
      end else begin
         case (state)
            FC_IDLE: begin
               if (start_build) begin
                  state    <= FC_SCAN;
                  scan_idx <= '0;
                  hist     <= '0;
               end
            end
            FC_SCAN: begin
               if ((depth_t'(scan_idx) < active_depth) && (scan_len != '0))
                  hist[scan_len] <= hist[scan_len] + 1'b1;
               if (depth_t'(scan_idx) + 1'b1 >= active_depth) begin
                  state    <= FC_PRELOAD;
                  len_idx  <= len_t'(1);
                  run_code <= '0;
               end else begin
                  scan_idx <= scan_idx + 1'b1;
               end
            end
            FC_PRELOAD: begin
               run_code <= next_code;
               if (int'(len_idx) == MAX_LEN)
                  state <= FC_READY;
               else
                  len_idx <= len_idx + 1'b1;
            end
            default: state <= FC_IDLE; // ready lasts one cycle
         endcase
         if (abort)
            state <= FC_IDLE;
      end
   end

endmodule

/* huff_code_counters.sv */
/*
 * per-length code counters, lengths 1..MAX_LEN
 * single preload port plus one one-hot increment port per lane
 */
`timescale 1ns/10ps

module huff_code_counters import huff_pkg::*; #(
   parameter int MAX_LEN = max_len,
   parameter int LANES   = syms_per_cycle
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              pre_wen,
   input  len_t                              pre_len,
   input  code_t                             pre_code,
   input  logic [LANES-1:0][MAX_LEN:1]       inc_onehot,
   output code_t [MAX_LEN:1]                 counts
);

   code_t [MAX_LEN:1] counts_nxt;

   always_comb begin
      for (int l = 1; l <= MAX_LEN; l++) begin
         if (pre_wen && (int'(pre_len) == l))
            counts_nxt[l] = pre_code;
         else
            counts_nxt[l] = counts[l];
         for (int i = 0; i < LANES; i++)
            counts_nxt[l] = counts_nxt[l] + code_t'(inc_onehot[i][l]); // lanes hitting l
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         counts <= '0;
      else
         counts <= counts_nxt;
   end

endmodule

/* huff_code_writer.sv */
/*
 * code table writer: walks the length table SYMS_PER_CYCLE symbols
 * per cycle and emits bit-reversed canonical codes per lane
 */
`timescale 1ns/10ps

module huff_code_writer import huff_pkg::*; #(
   parameter int MAX_SYMS       = max_syms,
   parameter int MAX_LEN        = max_len,
   parameter int SYMS_PER_CYCLE = syms_per_cycle
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    table_ready,
   input  logic                                    abort,
   input  len_t [MAX_SYMS-1:0]                     lens,
   input  depth_t                                  active_depth,
   input  code_t [MAX_LEN:1]                       counts,
   output logic [SYMS_PER_CYCLE-1:0][MAX_LEN:1]    inc_onehot,
   output logic [SYMS_PER_CYCLE-1:0]               code_wen,
   output sym_t                                    code_addr,
   output code_t [SYMS_PER_CYCLE-1:0]              code_data,
   output logic                                    code_last
);

   typedef enum logic {
      WR_IDLE,
      WR_WRITE
   } wr_state_t;

   wr_state_t  state, state_nxt;
   sym_t       sym_idx, sym_idx_nxt;
   depth_t     remain, remain_nxt;    // symbols left incl. this group

   len_t  [SYMS_PER_CYCLE-1:0] bl;
   code_t [SYMS_PER_CYCLE-1:0] raw_code;

   // lane lengths, lanes past the table end read as unused
   always_comb begin
      for (int i = 0; i < SYMS_PER_CYCLE; i++) begin
         if (int'(sym_idx) + i < MAX_SYMS)
            bl[i] = lens[int'(sym_idx) + i];
         else
            bl[i] = '0;
      end
   end

   // per-lane code, duplicates in lower lanes bump the value
   always_comb begin
      for (int i = 0; i < SYMS_PER_CYCLE; i++) begin
         if (bl[i] == '0) begin
            raw_code[i]  = '0;
            code_data[i] = '1;
         end else begin
            raw_code[i] = counts[bl[i]];
            for (int j = 0; j < i; j++)
               raw_code[i] = raw_code[i] + code_t'(bl[i] == bl[j]);
            code_data[i] = {<<{raw_code[i]}};
            code_data[i] = code_data[i] >> (MAX_LEN - int'(bl[i])); // reverse within length
         end
      end
   end

   assign code_addr = sym_idx;

   always_comb begin
      state_nxt   = state;
      sym_idx_nxt = sym_idx;
      remain_nxt  = remain;
      code_wen    = '0;
      code_last   = 1'b0;
      inc_onehot  = '0;

      case (state)
         WR_IDLE: begin
            if (table_ready) begin
               state_nxt   = WR_WRITE;
               sym_idx_nxt = '0;
               remain_nxt  = active_depth;
            end
         end
         WR_WRITE: begin
            for (int i = 0; i < SYMS_PER_CYCLE; i++) begin
               if ((bl[i] != '0) && (i < int'(remain))) begin
                  code_wen[i]          = 1'b1;
                  inc_onehot[i][bl[i]] = 1'b1;
               end
            end
            if (int'(remain) <= SYMS_PER_CYCLE) begin
               state_nxt   = WR_IDLE;
               sym_idx_nxt = '0;
               code_last   = 1'b1;
            end else begin
               sym_idx_nxt = sym_t'(int'(sym_idx) + SYMS_PER_CYCLE);
               remain_nxt  = depth_t'(int'(remain) - SYMS_PER_CYCLE);
            end
         end
         default: state_nxt = WR_IDLE;
      endcase

      if (abort)
         state_nxt = WR_IDLE;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= WR_IDLE;
         sym_idx <= '0;
         remain  <= '0;
      end else begin
         state   <= state_nxt;
         sym_idx <= sym_idx_nxt;
         remain  <= remain_nxt;
      end
   end

endmodule

/* huff_code_ram.sv */
/*
 * symbol-indexed code table
 * multi-lane write at consecutive symbols, combinational read
 */
`timescale 1ns/10ps

module huff_code_ram import huff_pkg::*; #(
   parameter int MAX_SYMS = max_syms,
   parameter int LANES    = syms_per_cycle
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic  [LANES-1:0]        code_wen,
   input  sym_t                     code_addr,
   input  code_t [LANES-1:0]        code_data,
   input  sym_t                     rd_sym,
   output code_t                    rd_code
);

   code_t mem [MAX_SYMS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int s = 0; s < MAX_SYMS; s++)
            mem[s] <= '0;
      end else begin
         for (int i = 0; i < LANES; i++) begin
            if (code_wen[i] && (int'(code_addr) + i < MAX_SYMS))
               mem[int'(code_addr) + i] <= code_data[i]; // lane i -> base + i
         end
      end
   end

   assign rd_code = (int'(rd_sym) < MAX_SYMS) ? mem[rd_sym] : '0;

endmodule

/* huff_table_builder.sv */
/*
 * top level of the canonical huffman table builder
 * register block, first-code scan, counters, writer, code table
 */
`timescale 1ns/10ps

module huff_table_builder import huff_pkg::*; #(
   parameter int MAX_SYMS       = max_syms,
   parameter int MAX_LEN        = max_len,
   parameter int SYMS_PER_CYCLE = syms_per_cycle
) (
   input  logic     clk,
   input  logic     rst_n,
   input  len_wr_t  len_wr,
   input  depth_t   depth,
   input  logic     start,
   input  logic     abort,
   input  sym_t     rd_sym,
   output code_t    rd_code,
   output logic     busy,
   output logic     done
);

   len_t  [MAX_SYMS-1:0]                     lens;
   depth_t                                   active_depth;
   logic                                     start_build;
   logic                                     pre_wen;
   len_t                                     pre_len;
   code_t                                    pre_code;
   logic                                     table_ready;
   logic  [SYMS_PER_CYCLE-1:0][MAX_LEN:1]    inc_onehot;
   code_t [MAX_LEN:1]                        counts;
   logic  [SYMS_PER_CYCLE-1:0]               code_wen;
   sym_t                                     code_addr;
   code_t [SYMS_PER_CYCLE-1:0]               code_data;
   logic                                     code_last;

   huff_len_regs #(.MAX_SYMS(MAX_SYMS)) len_regs_inst (
      .clk(clk), .rst_n(rst_n), .len_wr(len_wr), .depth(depth), .start(start),
      .abort(abort), .code_last(code_last), .lens(lens), .active_depth(active_depth),
      .start_build(start_build), .busy(busy), .done(done));

   huff_first_code #(.MAX_SYMS(MAX_SYMS), .MAX_LEN(MAX_LEN)) first_code_inst (
      .clk(clk), .rst_n(rst_n), .start_build(start_build), .abort(abort), .lens(lens),
      .active_depth(active_depth), .pre_wen(pre_wen), .pre_len(pre_len),
      .pre_code(pre_code), .table_ready(table_ready));

   huff_code_counters #(.MAX_LEN(MAX_LEN), .LANES(SYMS_PER_CYCLE)) code_counters_inst (
      .clk(clk), .rst_n(rst_n), .pre_wen(pre_wen), .pre_len(pre_len),
      .pre_code(pre_code), .inc_onehot(inc_onehot), .counts(counts));

   huff_code_writer #(
      .MAX_SYMS(MAX_SYMS), .MAX_LEN(MAX_LEN), .SYMS_PER_CYCLE(SYMS_PER_CYCLE)
   ) code_writer_inst (
      .clk(clk), .rst_n(rst_n), .table_ready(table_ready), .abort(abort), .lens(lens),
      .active_depth(active_depth), .counts(counts), .inc_onehot(inc_onehot),
      .code_wen(code_wen), .code_addr(code_addr), .code_data(code_data),
      .code_last(code_last));

   huff_code_ram #(.MAX_SYMS(MAX_SYMS), .LANES(SYMS_PER_CYCLE)) code_ram_inst (
      .clk(clk), .rst_n(rst_n), .code_wen(code_wen), .code_addr(code_addr),
      .code_data(code_data), .rd_sym(rd_sym), .rd_code(rd_code));

endmodule

/* tb_huff_table_builder.sv */
/*
 * testbench for the huffman table builder
 * table of length sets, canonical code model, busy/abort checks
 */
`timescale 1ns/10ps

module tb_huff_table_builder import huff_pkg::*; ();

   localparam int NCASES  = 6;
   localparam int TIMEOUT = 200;

   logic    clk, rst_n, start, abort, busy, done;
   len_wr_t len_wr;
   depth_t  depth;
   sym_t    rd_sym;
   code_t   rd_code;

   // lengths packed one nibble per symbol with symbol 0 in the low nibble
   // case kind 0 plain, 1 write while busy then rebuild, 2 abort first, 3 random
   logic [63:0] case_lens [NCASES] = '{64'h0000_0000_4423_3333, 64'h0000_0000_0033_3322,
      64'h0000_0000_5320_3302, 64'h4444_4444_4444_4444, 64'h0000_0008_8765_4321, 64'h0};
   int    case_depth [NCASES] = '{8, 6, 7, 16, 9, 16};
   int    case_kind  [NCASES] = '{0, 0, 0, 1, 2, 3};
   string case_name  [NCASES] = '{"deflate", "equal lengths", "zero length odd depth",
      "busy status", "abort", "random"};

   code_t model     [max_syms];
   bit    model_vld [max_syms];
   int    errors, checks, errs_before, seed;

   huff_table_builder huff_table_builder_inst (
      .clk(clk), .rst_n(rst_n), .len_wr(len_wr), .depth(depth), .start(start),
      .abort(abort), .rd_sym(rd_sym), .rd_code(rd_code), .busy(busy), .done(done));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_mismatch(input string sig, input int got, input int exp);
      $display("mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
      errors++;
   endtask

   function automatic code_t reverse_bits(input code_t c, input int len);
      code_t r;
      r = '0;
      for (int b = 0; b < len; b++)
         r[len-1-b] = c[b];
      return r;
   endfunction

   // kraft budget in 1/256 units keeps the set valid
   function automatic logic [63:0] random_lens();
      logic [63:0] l;
      int budget, len;
      l = '0;
      budget = 256;
      for (int s = 0; s < max_syms; s++) begin
         len = ($random(seed) & 15) % 9;
         while (len != 0 && len < 8 && (256 >> len) > budget)
            len++;
         if (len != 0 && (256 >> len) > budget)
            len = 0;
         if (len != 0)
            budget -= 256 >> len;
         l[4*s +: 4] = 4'(len);
      end
      return l;
   endfunction

   // canonical codes the deflate way with counts, first codes and in-order assignment
   task automatic update_model(input logic [63:0] l, input int d);
      int bl_count [max_len+1];
      int next_code [max_len+1];
      int code, len;
      bl_count = '{default: 0};
      for (int s = 0; s < d; s++)
         if (l[4*s +: 4] != 0)
            bl_count[l[4*s +: 4]]++;
      code = 0;
      for (int b = 1; b <= max_len; b++) begin
         code = (code + bl_count[b-1]) << 1;
         next_code[b] = code;
      end
      for (int s = 0; s < d; s++) begin
         len = int'(l[4*s +: 4]);
         if (len != 0) begin
            model[s] = reverse_bits(code_t'(next_code[len]), len);
            model_vld[s] = 1'b1;
            next_code[len]++;
         end
      end
   endtask

   task automatic load_lens(input logic [63:0] l);
      for (int s = 0; s < max_syms; s++) begin
         @(negedge clk);
         len_wr = '{valid: 1'b1, sym: sym_t'(s), len: l[4*s +: 4]};
      end
      @(negedge clk);
      len_wr = '0;
   endtask

   task automatic start_pulse(input int d);
      @(negedge clk);
      depth = depth_t'(d);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   // busy must hold until the cycle done pulses
   task automatic run_build(input int d, input bit write_busy);
      bit seen;
      seen = 1'b0;
      start_pulse(d);
      for (int n = 0; n < TIMEOUT && !seen; n++) begin
         @(negedge clk);
         if (write_busy && n == 1)
            len_wr = '{valid: 1'b1, sym: sym_t'(0), len: len_t'(1)}; // must be ignored
         else
            len_wr = '0;
         seen = done;
         assert (busy == !done) else report_mismatch("busy", busy, !done);
      end
      assert (seen)
         else begin
            $display("no done pulse within %0d cycles of start", TIMEOUT);
            errors++;
         end
   endtask

   task automatic run_abort(input int d);
      start_pulse(d);
      repeat (3) @(negedge clk);
      abort = 1'b1;
      @(negedge clk);
      abort = 1'b0;
      assert (!busy) else report_mismatch("busy", busy, 0);
      for (int n = 0; n < 40; n++) begin
         @(negedge clk);
         assert (!done) else report_mismatch("done", done, 0);
      end
   endtask

   task automatic check_table();
      for (int s = 0; s < max_syms; s++) begin
         @(negedge clk);
         rd_sym = sym_t'(s);
         #2;
         if (model_vld[s]) begin
            checks++;
            assert (rd_code == model[s])
               else report_mismatch($sformatf("rd_code[%0d]", s), rd_code, model[s]);
         end
      end
   endtask

   initial begin
      rst_n = 1'b0;
      start = 1'b0;
      abort = 1'b0;
      len_wr = '0;
      depth = '0;
      rd_sym = '0;
      errors = 0;
      checks = 0;
      seed = 32'habbc12bd;
      model_vld = '{default: 1'b0};
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      for (int c = 0; c < NCASES; c++) begin
         errs_before = errors;
         if (case_kind[c] == 3)
            case_lens[c] = random_lens();
         load_lens(case_lens[c]);
         if (case_kind[c] == 2) begin
            run_abort(case_depth[c]);
            check_table(); // aborted build leaves the table alone
         end
         run_build(case_depth[c], case_kind[c] == 1);
         update_model(case_lens[c], case_depth[c]);
         check_table();
         if (case_kind[c] == 1) begin
            run_build(case_depth[c], 1'b0); // same lengths without a reload
            check_table();
         end
         if (errors == errs_before)
            $display("case %0d %s: ok", c, case_name[c]);
         else
            $display("case %0d %s: %0d errors", c, case_name[c], errors - errs_before);
      end

      $display("%0d cases, %0d checks, %0d errors", NCASES, checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

/* huff_table_builder.f */
huff_pkg.sv
huff_len_regs.sv
huff_first_code.sv
huff_code_counters.sv
huff_code_writer.sv
huff_code_ram.sv
huff_table_builder.sv
tb_huff_table_builder.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the huffman table builder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_huff_table_builder \
   -f huff_table_builder.f \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "test passed" sim.log; then
   exit 0
else
   exit 1
fi
